/* tb.f */
+incdir+include
design/rv_pkg.sv
design/rv_reg_file.sv
design/rv_fetch.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_memory.sv
design/rv_core_top.sv
sim/rv_core_chk.sv
sim/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/rv_pkg.sv
      - design/rv_reg_file.sv
      - design/rv_fetch.sv
      - design/rv_decode.sv
      - design/rv_execute.sv
      - design/rv_memory.sv
      - design/rv_core_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/rv_core_chk.sv
      - sim/rv_core_tb.sv

/* sim/rv_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_core_tb import rv_pkg::*; ();

  localparam int NUM_TESTS       = 20;
  localparam int MAX_LEN         = 24;
  localparam int RESET_CYCLES    = 16;
  localparam int DRAIN_CYCLES    = 8;   // Quiet time to catch extra commits
  localparam int IMEM_AW         = $clog2(`RV_IMEM_WORDS);
  localparam int WATCHDOG_CYCLES =
    NUM_TESTS * (`RV_IMEM_WORDS + RESET_CYCLES + MAX_LEN * 2 + 40);

  logic                clock;
  logic                reset;
  logic                run;
  logic                prog_we;
  logic [IMEM_AW-1:0]  prog_addr;
  logic [`RV_XLEN-1:0] prog_data;
  commit_t             commit;

  logic [31:0] rng_state;
  logic [31:0] program_words [MAX_LEN];
  int          program_len;
  commit_t     expected_q [$];
  logic [31:0] model_regs [`RV_REG_COUNT];
  logic [31:0] model_mem [`RV_DMEM_WORDS];
  int          commit_count  = 0;
  int          checked_total = 0;
  int          error_count   = 0;

  rv_core_top rv_core_top_i (
    .clock(clock), .reset(reset), .run(run), .prog_we(prog_we),
    .prog_addr(prog_addr), .prog_data(prog_data), .commit(commit)
  );

  always #50 clock = ~clock;

  // ==================================================================
  // Random numbers and checking
  // ==================================================================

  function automatic logic [31:0] lcg_next();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic int random_below(input int n);
    logic [31:0] r;
    r = lcg_next();
    return int'((r >> 8) % n);  // Upper bits, the low ones cycle fast
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: actual 0x%08h expected 0x%08h", name, actual, expected);
      error_count++;
    end
  endtask

  // ==================================================================
  // Program generator with sequential reference model
  // ==================================================================

  function automatic commit_t base_entry(input logic [31:0] word);
    commit_t entry;
    entry           = '0;
    entry.valid     = 1'b1;
    entry.pc        = 32'(program_len * 4);
    entry.rd        = word[11:7];
    entry.reg_write = (word[11:7] != 5'd0);  // x0 never written
    return entry;
  endfunction

  task automatic append(input logic [31:0] word, input commit_t entry, input logic keep);
    if (keep) begin
      expected_q.push_back(entry);
    end
    program_words[program_len] = word;
    program_len++;
  endtask

  task automatic add_alu(input logic [31:0] word, input logic [31:0] result);
    commit_t entry;
    entry      = base_entry(word);
    entry.data = result;
    if (entry.reg_write) begin
      model_regs[entry.rd] = result;
    end
    append(word, entry, 1'b1);
  endtask

  task automatic add_load(input logic [4:0] rd, input int word_idx);
    logic [11:0] imm;
    logic [31:0] word;
    commit_t     entry;
    imm        = 12'(word_idx * 4);  // Base x0, address is the immediate
    word       = {imm, 5'd0, 3'b010, rd, 7'b0000011};
    entry      = base_entry(word);
    entry.data = model_mem[word_idx];
    entry.addr = {20'd0, imm};
    if (entry.reg_write) begin
      model_regs[rd] = entry.data;
    end
    append(word, entry, 1'b1);
  endtask

  task automatic add_store(input logic [4:0] rs2, input int word_idx);
    logic [11:0] imm;
    logic [31:0] word;
    commit_t     entry;
    imm              = 12'(word_idx * 4);
    word             = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'b0100011};
    entry            = base_entry(word);
    entry.reg_write  = 1'b0;
    entry.mem_write  = 1'b1;
    entry.addr       = {20'd0, imm};
    entry.store_data = model_regs[rs2];
    model_mem[word_idx] = model_regs[rs2];
    append(word, entry, 1'b1);
  endtask

  task automatic build_program();
    int          target_len;
    int          word_idx;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [31:0] a;
    logic [31:0] b;
    program_len = 0;
    expected_q.delete();
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    foreach (model_mem[i]) begin
      model_mem[i] = '0;
    end
    target_len = 8 + random_below(MAX_LEN - 10);
    while (program_len < target_len) begin
      rd       = 5'(random_below(5));  // Few registers, many dependencies
      rs1      = 5'(random_below(5));
      rs2      = 5'(random_below(5));
      imm12    = 12'(lcg_next() >> 12);
      imm20    = 20'(lcg_next() >> 12);
      word_idx = random_below(8);
      a        = model_regs[rs1];
      b        = model_regs[rs2];
      case (random_below(9))
        0: add_alu({imm12, rs1, 3'b000, rd, 7'b0010011}, a + {{20{imm12[11]}}, imm12});
        1: add_alu({7'b0, imm12[4:0], rs1, 3'b101, rd, 7'b0010011}, a >> imm12[4:0]);
        2: add_alu({7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011}, a + b);
        3: add_alu({7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011}, a - b);
        4: add_alu({7'b0000001, rs2, rs1, 3'b000, rd, 7'b0110011}, a * b);
        5: add_alu({imm20, rd, 7'b0010111}, 32'(program_len * 4) + {imm20, 12'b0});
        6: add_load(rd, word_idx);
        7: add_store(rs2, word_idx);
        default: begin
          // Load and an immediate user of its result
          add_load(rd, word_idx);
          add_alu({7'b0000000, rs2, rd, 3'b000, rs1, 7'b0110011},
                  model_regs[rd] + model_regs[rs2]);
        end
      endcase
    end
    // Branch and XORI words fall outside the subset
    append({imm20, 5'd1, 7'b1100011}, '0, 1'b0);
    append({imm12, rs1, 3'b100, rd, 7'b0010011}, '0, 1'b0);
  endtask

  // ==================================================================
  // Test sequence, monitor and watchdog
  // ==================================================================

  task automatic run_test(input int test_num);
    int errors_before;
    errors_before = error_count;
    build_program();
    for (int addr = 0; addr < `RV_IMEM_WORDS; addr++) begin
      @(posedge clock);
      #1;
      prog_we   = 1'b1;
      prog_addr = IMEM_AW'(addr);
      prog_data = (addr < program_len) ? program_words[addr] : '0;
    end
    @(posedge clock);
    #1;
    prog_we = 1'b0;
    reset   = 1'b1;
    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset        = 1'b0;
    commit_count = 0;
    run          = 1'b1;
    while (commit_count < expected_q.size()) begin
      @(posedge clock);
    end
    repeat (DRAIN_CYCLES) @(posedge clock);
    #1;
    run = 1'b0;
    check_value("commit_count", commit_count, expected_q.size());
    checked_total += commit_count;
    $display("Test %0d done: %0d words, %0d commits expected, %0d seen, %0d errors",
             test_num, program_len, expected_q.size(), commit_count,
             error_count - errors_before);
  endtask

  // Sampled on the falling edge, away from the commit register update
  always @(negedge clock) begin
    if (!reset && commit.valid) begin
      if (commit_count < expected_q.size()) begin
        check_value("commit.pc", commit.pc, expected_q[commit_count].pc);
        check_value("commit.rd", 32'(commit.rd), 32'(expected_q[commit_count].rd));
        check_value("commit.reg_write", 32'(commit.reg_write),
                    32'(expected_q[commit_count].reg_write));
        check_value("commit.data", commit.data, expected_q[commit_count].data);
        check_value("commit.mem_write", 32'(commit.mem_write),
                    32'(expected_q[commit_count].mem_write));
        check_value("commit.addr", commit.addr, expected_q[commit_count].addr);
        check_value("commit.store_data", commit.store_data,
                    expected_q[commit_count].store_data);
      end else begin
        $display("Unexpected commit at pc 0x%08h, only %0d were predicted",
                 commit.pc, expected_q.size());
        error_count++;
      end
      commit_count++;
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clock     = 1'b0;
    reset     = 1'b1;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    rng_state = 32'h5a0e_4305;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("Tests %0d, commits checked %0d, errors %0d",
             NUM_TESTS, checked_total, error_count);
    if (error_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/rv_core_chk.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_core_chk import rv_pkg::*; (
  input logic    clock,
  input logic    reset,
  input logic    stall,
  input commit_t commit
);

  logic                seen_commit;
  logic [`RV_XLEN-1:0] last_pc;  // pc of the previous commit

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      seen_commit <= 1'b0;
      last_pc     <= '0;
    end else if (commit.valid) begin
      seen_commit <= 1'b1;
      last_pc     <= commit.pc;
    end
  end

  rd_nonzero: assert property (@(posedge clock) disable iff (reset)
    commit.valid && commit.reg_write |-> commit.rd != '0)
    else $error("commit with reg_write set targets x0");

  // In-order retirement, one word apart
  pc_step: assert property (@(posedge clock) disable iff (reset)
    commit.valid && seen_commit |-> commit.pc == last_pc + 32'd4)
    else $error("commit pc 0x%08h does not follow 0x%08h", commit.pc, last_pc);

  single_stall: assert property (@(posedge clock) disable iff (reset)
    stall |=> !stall)
    else $error("stall held for two cycles in a row");

endmodule

bind rv_core_top rv_core_chk rv_core_chk_i (
  .clock(clock), .reset(reset), .stall(stall), .commit(commit)
);

`default_nettype wire

/* design/rv_core_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_core_top import rv_pkg::*; (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               run,
  input  logic                               prog_we,
  input  logic [$clog2(`RV_IMEM_WORDS)-1:0]  prog_addr,
  input  logic [`RV_XLEN-1:0]                prog_data,
  output commit_t                            commit
);

  fetch_t                     fetch;
  decode_t                    decode;
  exec_t                      exec;
  logic                       stall;    // Load-use bubble request

  // Register file read and write ports
  logic [`RV_REG_IDX_W-1:0]   rs1_idx;
  logic [`RV_REG_IDX_W-1:0]   rs2_idx;
  logic [`RV_XLEN-1:0]        rs1_val;
  logic [`RV_XLEN-1:0]        rs2_val;
  logic                       wr_en;
  logic [`RV_REG_IDX_W-1:0]   wr_idx;
  logic [`RV_XLEN-1:0]        wr_data;

  rv_fetch rv_fetch_i (
    .clock(clock), .reset(reset), .run(run), .stall(stall),
    .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
    .fetch(fetch)
  );

  rv_decode rv_decode_i (
    .clock(clock), .reset(reset), .stall(stall), .fetch(fetch),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
    .decode(decode)
  );

  rv_reg_file rv_reg_file_i (
    .clock(clock), .reset(reset),
    .rs1_idx(rs1_idx), .rs2_idx(rs2_idx), .rs1_val(rs1_val), .rs2_val(rs2_val),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
  );

  rv_execute rv_execute_i (
    .clock(clock), .reset(reset), .decode(decode), .commit(commit),
    .stall(stall), .exec(exec)
  );

  rv_memory rv_memory_i (
    .clock(clock), .reset(reset), .exec(exec), .commit(commit),
    .wr_en(wr_en), .wr_idx(wr_idx), .wr_data(wr_data)
  );

endmodule

`default_nettype wire

/* design/rv_memory.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_memory import rv_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  exec_t                     exec,
  output commit_t                   commit,
  output logic                      wr_en,
  output logic [`RV_REG_IDX_W-1:0]  wr_idx,
  output logic [`RV_XLEN-1:0]       wr_data
);

  localparam int DMEM_AW = $clog2(`RV_DMEM_WORDS);

  logic [`RV_XLEN-1:0] dmem [`RV_DMEM_WORDS];
  logic [DMEM_AW-1:0]  word_idx;
  logic [`RV_XLEN-1:0] load_data;
  commit_t             commit_next;

  assign word_idx  = exec.result[2 +: DMEM_AW];  // Word aligned access
  assign load_data = dmem[word_idx];

  // Write-through data memory, cleared so loads start from zero
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
        dmem[i] <= '0;
      end
    end else if (exec.valid && exec.mem_write) begin
      dmem[word_idx] <= exec.store_data;
    end
  end

  always_comb begin
    commit_next           = '0;
    commit_next.valid     = exec.valid;
    commit_next.pc        = exec.pc;
    commit_next.rd        = exec.rd;
    commit_next.reg_write = exec.reg_write;
    commit_next.mem_write = exec.mem_write;
    if (exec.mem_read) begin
      commit_next.data = load_data;
      commit_next.addr = exec.result;
    end else if (exec.mem_write) begin
      commit_next.addr       = exec.result;
      commit_next.store_data = exec.store_data;
    end else begin
      commit_next.data = exec.result;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      commit <= '0;
    end else begin
      commit <= commit_next;
    end
  end

  // Write-back straight from the commit register
  assign wr_en   = commit.valid && commit.reg_write;
  assign wr_idx  = commit.rd;
  assign wr_data = commit.data;

endmodule

`default_nettype wire

/* design/rv_execute.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_execute import rv_pkg::*; (
  input  logic     clock,
  input  logic     reset,
  input  decode_t  decode,
  input  commit_t  commit,
  output logic     stall,
  output exec_t    exec
);

  logic                fwd_ex_a;
  logic                fwd_ex_b;
  logic                fwd_cm_a;
  logic                fwd_cm_b;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] op_b;     // Forwarded rs2, also the store data
  logic [`RV_XLEN-1:0] alu_b;
  logic [`RV_XLEN-1:0] alu_result;

  // ==================================================================
  // Hazards and forwarding
  // ==================================================================

  // Held load feeds the next instruction, wait one cycle for its data
  assign stall = exec.valid && exec.mem_read && exec.reg_write && decode.valid &&
                 ((exec.rd == decode.rs1) || (exec.rd == decode.rs2));

  // A load result is not ready in execute, so only ALU entries forward from here
  assign fwd_ex_a = exec.valid && exec.reg_write && !exec.mem_read &&
                    (exec.rd == decode.rs1);
  assign fwd_ex_b = exec.valid && exec.reg_write && !exec.mem_read &&
                    (exec.rd == decode.rs2);
  assign fwd_cm_a = commit.valid && commit.reg_write && (commit.rd == decode.rs1);
  assign fwd_cm_b = commit.valid && commit.reg_write && (commit.rd == decode.rs2);

  // Newest producer wins
  assign op_a = fwd_ex_a ? exec.result :
                fwd_cm_a ? commit.data : decode.rs1_val;
  assign op_b = fwd_ex_b ? exec.result :
                fwd_cm_b ? commit.data : decode.rs2_val;

  assign alu_b = decode.use_imm ? decode.imm : op_b;

  // ==================================================================
  // ALU
  // ==================================================================

  always_comb begin
    case (decode.alu_op)
      alu_add:    alu_result = op_a + alu_b;
      alu_sub:    alu_result = op_a - alu_b;
      alu_mul:    alu_result = op_a * alu_b;  // Low 32 bits
      alu_srl:    alu_result = op_a >> alu_b[4:0];
      alu_add_pc: alu_result = decode.pc + alu_b;
      default:    alu_result = alu_b;          // Pass B
    endcase
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      exec <= '0;
    end else if (stall) begin
      exec <= '0;  // Insert bubble
    end else begin
      exec.valid      <= decode.valid;
      exec.pc         <= decode.pc;
      exec.rd         <= decode.rd;
      exec.reg_write  <= decode.reg_write;
      exec.mem_read   <= decode.mem_read;
      exec.mem_write  <= decode.mem_write;
      exec.result     <= alu_result;
      exec.store_data <= op_b;
    end
  end

endmodule

`default_nettype wire

/* design/rv_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_decode import rv_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      stall,
  input  fetch_t                    fetch,
  output logic [`RV_REG_IDX_W-1:0]  rs1_idx,
  output logic [`RV_REG_IDX_W-1:0]  rs2_idx,
  input  logic [`RV_XLEN-1:0]       rs1_val,
  input  logic [`RV_XLEN-1:0]       rs2_val,
  output decode_t                   decode
);

  logic [6:0]               opcode;
  logic [2:0]               funct3;
  logic [6:0]               funct7;
  logic [`RV_REG_IDX_W-1:0] rd;
  logic [`RV_REG_IDX_W-1:0] rs1;
  logic [`RV_REG_IDX_W-1:0] rs2;
  logic [`RV_XLEN-1:0]      imm_i;
  logic [`RV_XLEN-1:0]      imm_s;
  logic [`RV_XLEN-1:0]      imm_u;
  logic                     known;
  logic                     uses_rs1;
  logic                     uses_rs2;
  decode_t                  dec_next;

  // ==================================================================
  // Field extraction and immediates
  // ==================================================================

  assign opcode = fetch.instr[6:0];
  assign rd     = fetch.instr[11:7];
  assign funct3 = fetch.instr[14:12];
  assign rs1    = fetch.instr[19:15];
  assign rs2    = fetch.instr[24:20];
  assign funct7 = fetch.instr[31:25];

  assign imm_i = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
  assign imm_s = {{20{fetch.instr[31]}}, fetch.instr[31:25], fetch.instr[11:7]};
  assign imm_u = {fetch.instr[31:12], 12'b0};

  // ==================================================================
  // Control decode
  // ==================================================================

  always_comb begin
    dec_next        = '0;
    dec_next.pc     = fetch.pc;
    dec_next.alu_op = alu_pass_b;
    dec_next.rd     = rd;
    known           = 1'b1;
    uses_rs1        = 1'b1;
    uses_rs2        = 1'b0;
    case (opcode)
      op_imm: begin
        dec_next.imm       = imm_i;  // SRLI takes shamt from imm[4:0]
        dec_next.use_imm   = 1'b1;
        dec_next.reg_write = 1'b1;
        if (funct3 == 3'b000) begin
          dec_next.alu_op = alu_add;
        end else if (funct3 == 3'b101 && funct7 == 7'b0000000) begin
          dec_next.alu_op = alu_srl;
        end else begin
          known = 1'b0;
        end
      end
      op_reg: begin
        uses_rs2           = 1'b1;
        dec_next.reg_write = 1'b1;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: dec_next.alu_op = alu_add;
          {7'b0100000, 3'b000}: dec_next.alu_op = alu_sub;
          {7'b0000001, 3'b000}: dec_next.alu_op = alu_mul;
          default:              known = 1'b0;
        endcase
      end
      op_load: begin
        dec_next.alu_op    = alu_add;
        dec_next.imm       = imm_i;
        dec_next.use_imm   = 1'b1;
        dec_next.reg_write = 1'b1;
        dec_next.mem_read  = 1'b1;
      end
      op_store: begin
        uses_rs2           = 1'b1;  // Store data
        dec_next.alu_op    = alu_add;
        dec_next.imm       = imm_s;
        dec_next.use_imm   = 1'b1;
        dec_next.mem_write = 1'b1;
      end
      op_auipc: begin
        uses_rs1           = 1'b0;
        dec_next.alu_op    = alu_add_pc;
        dec_next.imm       = imm_u;
        dec_next.use_imm   = 1'b1;
        dec_next.reg_write = 1'b1;
      end
      default: known = 1'b0;
    endcase

    dec_next.valid = fetch.valid && known;
    dec_next.rs1   = uses_rs1 ? rs1 : '0;
    dec_next.rs2   = uses_rs2 ? rs2 : '0;
    if (rd == '0 || !dec_next.valid) begin
      dec_next.reg_write = 1'b0;
    end
    if (!dec_next.valid) begin  // Bubble carries no side effects
      dec_next.mem_read  = 1'b0;
      dec_next.mem_write = 1'b0;
    end
  end

  // While stalled, re-read the held sources so a write retiring meanwhile is seen
  assign rs1_idx = stall ? decode.rs1 : dec_next.rs1;
  assign rs2_idx = stall ? decode.rs2 : dec_next.rs2;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      decode <= '0;
    end else begin
      if (!stall) begin
        decode <= dec_next;
      end
      decode.rs1_val <= rs1_val;
      decode.rs2_val <= rs2_val;
    end
  end

endmodule

`default_nettype wire

/* design/rv_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_fetch import rv_pkg::*; (
  input  logic                               clock,
  input  logic                               reset,
  input  logic                               run,
  input  logic                               stall,
  input  logic                               prog_we,
  input  logic [$clog2(`RV_IMEM_WORDS)-1:0]  prog_addr,
  input  logic [`RV_XLEN-1:0]                prog_data,
  output fetch_t                             fetch
);

  localparam int IMEM_AW = $clog2(`RV_IMEM_WORDS);

  logic [`RV_XLEN-1:0] imem [`RV_IMEM_WORDS];
  logic [`RV_XLEN-1:0] pc;
  logic [`RV_XLEN-1:0] instr_word;
  logic                in_range;

  // Program load, only while the core is halted
  always_ff @(posedge clock) begin
    if (prog_we && !run) begin
      imem[prog_addr] <= prog_data;
    end
  end

  // Past the end of memory the core sees zero words, which decode drops
  assign in_range   = (pc[`RV_XLEN-1:2] < `RV_IMEM_WORDS);
  assign instr_word = in_range ? imem[pc[2 +: IMEM_AW]] : '0;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      pc    <= `RV_RESET_PC;
      fetch <= '0;
    end else if (!run) begin
      fetch.valid <= 1'b0;  // Halted, feed bubbles
    end else if (!stall) begin
      fetch <= '{valid: 1'b1, pc: pc, instr: instr_word};
      pc    <= pc + 32'd4;
    end
  end

endmodule

`default_nettype wire

/* design/rv_reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rv_settings.svh"

module rv_reg_file (
  input  logic                      clock,
  input  logic                      reset,
  input  logic [`RV_REG_IDX_W-1:0]  rs1_idx,
  input  logic [`RV_REG_IDX_W-1:0]  rs2_idx,
  output logic [`RV_XLEN-1:0]       rs1_val,
  output logic [`RV_XLEN-1:0]       rs2_val,
  input  logic                      wr_en,
  input  logic [`RV_REG_IDX_W-1:0]  wr_idx,
  input  logic [`RV_XLEN-1:0]       wr_data
);

  logic [`RV_XLEN-1:0] regs [`RV_REG_COUNT];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en && wr_idx != '0) begin
      regs[wr_idx] <= wr_data;
    end
  end

  // x0 reads zero; a same-cycle write is bypassed to the reader
  assign rs1_val = (rs1_idx == '0)                 ? '0      :
                   (wr_en && wr_idx == rs1_idx)    ? wr_data : regs[rs1_idx];
  assign rs2_val = (rs2_idx == '0)                 ? '0      :
                   (wr_en && wr_idx == rs2_idx)    ? wr_data : regs[rs2_idx];

endmodule

`default_nettype wire

/* design/rv_pkg.sv */
`default_nettype none

`include "rv_settings.svh"

package rv_pkg;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    op_load  = 7'b0000011,
    op_imm   = 7'b0010011,
    op_auipc = 7'b0010111,
    op_store = 7'b0100011,
    op_reg   = 7'b0110011
  } opcode_e;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_mul,
    alu_srl,
    alu_pass_b,
    alu_add_pc  // AUIPC, pc plus immediate
  } alu_op_e;

  typedef struct packed {
    logic                      valid;
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_XLEN-1:0]       instr;
  } fetch_t;

  typedef struct packed {
    logic                      valid;
    logic [`RV_XLEN-1:0]       pc;
    alu_op_e                   alu_op;
    logic [`RV_REG_IDX_W-1:0]  rs1;      // Zero when the source is unused
    logic [`RV_REG_IDX_W-1:0]  rs2;
    logic [`RV_XLEN-1:0]       rs1_val;
    logic [`RV_XLEN-1:0]       rs2_val;
    logic [`RV_XLEN-1:0]       imm;
    logic                      use_imm;
    logic [`RV_REG_IDX_W-1:0]  rd;
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
  } decode_t;

  typedef struct packed {
    logic                      valid;
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_REG_IDX_W-1:0]  rd;
    logic                      reg_write;
    logic                      mem_read;
    logic                      mem_write;
    logic [`RV_XLEN-1:0]       result;   // ALU value or byte address
    logic [`RV_XLEN-1:0]       store_data;
  } exec_t;

  typedef struct packed {
    logic                      valid;
    logic [`RV_XLEN-1:0]       pc;
    logic [`RV_REG_IDX_W-1:0]  rd;
    logic                      reg_write;
    logic [`RV_XLEN-1:0]       data;
    logic                      mem_write;
    logic [`RV_XLEN-1:0]       addr;
    logic [`RV_XLEN-1:0]       store_data;
  } commit_t;

endpackage

`default_nettype wire

/* include/rv_settings.svh */
`ifndef RV_SETTINGS_SVH
`define RV_SETTINGS_SVH

// ====================================================================
// Datapath widths
// ====================================================================

`define RV_XLEN      32  // Data and address width
`define RV_REG_COUNT 32
`define RV_REG_IDX_W 5   // Register index width

// ====================================================================
// Memories
// ====================================================================

// Instruction memory depth in words, loaded through the program port
`define RV_IMEM_WORDS 64
`define RV_DMEM_WORDS 64  // Data memory depth in words

// ====================================================================
// Fetch
// ====================================================================

`define RV_RESET_PC 32'h0000_0000

`endif
